/* compile.f */
+incdir+rtl
rtl/ps2_pkg.sv
rtl/key_event_if.sv
rtl/ps2_rx_frame.sv
rtl/ps2_ascii_map.sv
rtl/ps2_key_decoder.sv
rtl/ps2_key_buffer.sv
rtl/ps2_keyboard_rx.sv
tb/tb_ps2_keyboard_rx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PS/2 keyboard receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_ps2_keyboard_rx

sim_out=$(./obj_dir/Vtb_ps2_keyboard_rx)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "=== PASS ==="; then
  exit 0
else
  exit 1
fi

/* tb/tb_ps2_keyboard_rx.sv */
/*
  Testbench for the receive-only PS/2 keyboard controller.
  Keyboard model runs 10 clk cycles per ps2 clock half period.
  Expected ASCII table covers only the codes used here.
*/
`default_nettype none
`include "ps2_macros.svh"

module tb_ps2_keyboard_rx;

  localparam int BIT_CYCLES  = 20;              // One full ps2 clock period
  localparam int FRAME_COUNT = 12;              // Frames sent over all tests, rounded up
  localparam int MARGIN      = 2000;            // Idle gaps and handshakes
  localparam int RUN_LIMIT   = FRAME_COUNT * `PS2_FRAME_BITS * BIT_CYCLES + MARGIN;

  logic       clk = 1'b0;
  logic       reset;
  logic       ps2_clk_i, ps2_data_i;
  logic       rx_valid_o, rx_ready_i;
  logic [7:0] rx_scan_code_o, rx_ascii_o;
  logic       rx_released_o, rx_shift_o;

  logic       xfer, xfer_q;
  logic       event_allowed, data_check, hold_check, shift_check;
  logic [7:0] exp_code, exp_ascii;
  logic       exp_rel, exp_shift;
  logic       left_model, right_model;      // Keyboard side shift state
  int         errors;
  int unsigned rnd;
  string      test_name;

  ps2_keyboard_rx #(
    .WATCHDOG_CYCLES (64)
  ) u_dut (
    .clk            (clk),
    .reset          (reset),
    .ps2_clk_i      (ps2_clk_i),
    .ps2_data_i     (ps2_data_i),
    .rx_valid_o     (rx_valid_o),
    .rx_ready_i     (rx_ready_i),
    .rx_scan_code_o (rx_scan_code_o),
    .rx_ascii_o     (rx_ascii_o),
    .rx_released_o  (rx_released_o),
    .rx_shift_o     (rx_shift_o)
  );

  always #4 clk = ~clk;

  assign xfer = rx_valid_o && rx_ready_i;

  always @(posedge clk)
    xfer_q <= xfer;                           // Transfer seen last cycle

  task automatic report_mismatch(input string field, input logic [7:0] expv,
                                 input logic [7:0] actv);
    errors++;
    $display("mismatch %s: %s expected %h actual %h", test_name, field, expv, actv);
  endtask

  a_idle: assert property (@(posedge clk) disable iff (reset) !event_allowed |-> !rx_valid_o)
    else begin
      errors++;
      $display("unexpected key event in %s", test_name);
    end
  a_code: assert property (@(posedge clk) disable iff (reset)
                           (xfer || data_check) |-> (rx_scan_code_o == exp_code))
    else report_mismatch("scan_code", $sampled(exp_code), $sampled(rx_scan_code_o));
  a_ascii: assert property (@(posedge clk) disable iff (reset)
                            (xfer || data_check) |-> (rx_ascii_o == exp_ascii))
    else report_mismatch("ascii", $sampled(exp_ascii), $sampled(rx_ascii_o));
  a_rel: assert property (@(posedge clk) disable iff (reset)
                          (xfer || data_check) |-> (rx_released_o == exp_rel))
    else report_mismatch("released", {7'd0, $sampled(exp_rel)}, {7'd0, $sampled(rx_released_o)});
  a_shift: assert property (@(posedge clk) disable iff (reset)
                            shift_check |-> (rx_shift_o == exp_shift))
    else report_mismatch("shift", {7'd0, $sampled(exp_shift)}, {7'd0, $sampled(rx_shift_o)});
  a_hold: assert property (@(posedge clk) disable iff (reset) hold_check |-> rx_valid_o)
    else begin
      errors++;
      $display("rx_valid_o dropped while held in %s", test_name);
    end
  a_fall: assert property (@(posedge clk) disable iff (reset) xfer_q |-> !rx_valid_o)
    else begin
      errors++;
      $display("rx_valid_o still high after transfer in %s", test_name);
    end

  // US layout set 2, only what the tests send
  function automatic logic [7:0] expected_ascii(input logic [7:0] code, input logic shifted);
    logic [7:0] result;
    case (code)
      8'h1C:   result = shifted ? 8'h41 : 8'h61;
      default: result = `PS2_UNKNOWN_ASCII;  // 12 and 0F are unlisted
    endcase
    return result;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Data changes mid high phase, keyboard style
  task automatic send_bit(input logic b);
    @(posedge clk);
    ps2_data_i <= b;
    idle_cycles(5);
    ps2_clk_i <= 1'b0;                        // Receiver samples here
    idle_cycles(10);
    ps2_clk_i <= 1'b1;
    idle_cycles(4);
  endtask

  task automatic send_frame(input logic [7:0] code);
    logic [`PS2_FRAME_BITS-1:0] bits;
    bits = {1'b1, ~^code, code, 1'b0};        // Stop, odd parity, data, start
    for (int i = 0; i < `PS2_FRAME_BITS; i++)
      send_bit(bits[i]);
  endtask

  // Sets the expected event and steps the keyboard shift model
  task automatic expect_key(input logic [7:0] code, input logic rel);
    exp_code  <= code;
    exp_ascii <= expected_ascii(code, left_model || right_model); // Shift before this code
    exp_rel   <= rel;
    if (code == `PS2_LEFT_SHIFT)
      left_model = !rel;
    if (code == `PS2_RIGHT_SHIFT)
      right_model = !rel;
  endtask

  // Returns just after the transfer edge, or after the valid edge
  task automatic wait_handshake(input logic with_ready);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(rx_valid_o && (rx_ready_i || !with_ready)) && waited < 100)
    begin
      waited++;
      @(negedge clk);
    end
    if (waited >= 100)
    begin
      errors++;
      $display("no key event arrived in %s", test_name);
    end
    @(posedge clk);
  endtask

  task automatic type_key(input logic [7:0] code, input logic rel);
    if (rel)
      send_frame(`PS2_RELEASE_CODE);          // Prefix alone gives no event
    expect_key(code, rel);
    event_allowed <= 1'b1;
    shift_check   <= 1'b0;
    rx_ready_i    <= 1'b0;                    // Event waits in the buffer
    send_frame(code);
    rx_ready_i    <= 1'b1;
    wait_handshake(1'b1);
    event_allowed <= 1'b0;
    exp_shift     <= left_model || right_model;
    shift_check   <= 1'b1;
    idle_cycles(10);
  endtask

  initial
  begin
    errors = 0;
    repeat (RUN_LIMIT) @(posedge clk);
    $display("simulation stopped after %0d cycles without finishing", RUN_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    void'($urandom(32'hbf395887));
    reset         = 1'b1;
    ps2_clk_i     = 1'b1;                     // Lines idle high
    ps2_data_i    = 1'b1;
    rx_ready_i    = 1'b0;
    event_allowed = 1'b0;
    data_check    = 1'b0;
    hold_check    = 1'b0;
    shift_check   = 1'b0;
    exp_code      = 8'h00;
    exp_ascii     = 8'h00;
    exp_rel       = 1'b0;
    exp_shift     = 1'b0;
    left_model    = 1'b0;
    right_model   = 1'b0;
    test_name     = "reset_idle";
    idle_cycles(2);
    reset <= 1'b0;

    // Outputs zero and quiet while lines idle
    rx_ready_i  <= 1'b1;
    data_check  <= 1'b1;
    shift_check <= 1'b1;
    idle_cycles(50);
    data_check  <= 1'b0;

    test_name = "single_key";
    rx_ready_i <= 1'b0;
    expect_key(8'h1C, 1'b0);
    event_allowed <= 1'b1;
    send_frame(8'h1C);
    wait_handshake(1'b0);
    hold_check <= 1'b1;                       // Held value must not move
    data_check <= 1'b1;
    idle_cycles(20);
    hold_check <= 1'b0;
    data_check <= 1'b0;
    rx_ready_i <= 1'b1;
    wait_handshake(1'b1);
    event_allowed <= 1'b0;
    idle_cycles(10);

    test_name = "release_prefix";
    type_key(8'h1C, 1'b1);
    idle_cycles(300);                         // No second event

    test_name = "shift_keys";
    type_key(`PS2_LEFT_SHIFT, 1'b0);
    type_key(8'h1C, 1'b0);
    type_key(`PS2_LEFT_SHIFT, 1'b1);
    type_key(8'h0F, 1'b0);

    test_name = "overwrite";
    rx_ready_i    <= 1'b0;
    event_allowed <= 1'b1;
    expect_key(8'h1C, 1'b0);
    send_frame(8'h1C);
    expect_key(8'h0F, 1'b0);
    send_frame(8'h0F);                        // Replaces the unread 1C
    hold_check <= 1'b1;
    data_check <= 1'b1;
    idle_cycles(10);
    hold_check <= 1'b0;
    data_check <= 1'b0;
    rx_ready_i <= 1'b1;
    wait_handshake(1'b1);
    event_allowed <= 1'b0;
    idle_cycles(10);

    test_name = "partial_frame";
    for (int i = 0; i < 3; i++)
    begin
      rnd = $urandom();
      send_bit(rnd[0]);
    end
    idle_cycles(100);                         // Past the 64-cycle watchdog
    type_key(8'h1C, 1'b0);

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ps2_keyboard_rx.sv */
/*
  Receive-only PS/2 keyboard controller, no host-to-keyboard path.
  ps2_clk_i and ps2_data_i may be asynchronous to clk.
  rx_shift_o is a live level, the other outputs follow valid/ready.
*/
`default_nettype none

module ps2_keyboard_rx #(
  parameter int WATCHDOG_CYCLES = 3000    // About 60 us of clk
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 ps2_clk_i,
  input  wire logic                 ps2_data_i,
  output      logic                 rx_valid_o,
  input  wire logic                 rx_ready_i,
  output      ps2_pkg::scan_code_t  rx_scan_code_o,
  output      ps2_pkg::ascii_t      rx_ascii_o,
  output      logic                 rx_released_o,
  output      logic                 rx_shift_o
);

  logic                 code_valid;
  ps2_pkg::scan_code_t  code;

  key_event_if ev_if ();

  ps2_rx_frame #(
    .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
  ) u_rx_frame (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk_i    (ps2_clk_i),
    .ps2_data_i   (ps2_data_i),
    .code_valid_o (code_valid),
    .code_o       (code)
  );

  ps2_key_decoder u_key_decoder (
    .clk          (clk),
    .reset        (reset),
    .code_valid_i (code_valid),
    .code_i       (code),
    .shift_o      (rx_shift_o),
    .ev           (ev_if.producer)
  );

  ps2_key_buffer u_key_buffer (
    .clk          (clk),
    .reset        (reset),
    .ev           (ev_if.consumer),
    .valid_o      (rx_valid_o),
    .ready_i      (rx_ready_i),
    .scan_code_o  (rx_scan_code_o),
    .ascii_o      (rx_ascii_o),
    .released_o   (rx_released_o)
  );

endmodule

`default_nettype wire

/* rtl/ps2_key_buffer.sv */
/*
  Single-entry output register with valid/ready.
  The keyboard cannot be stalled: a new event overwrites unread data.
*/
`default_nettype none

module ps2_key_buffer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  key_event_if.consumer             ev,
  output      logic                 valid_o,
  input  wire logic                 ready_i,
  output      ps2_pkg::scan_code_t  scan_code_o,
  output      ps2_pkg::ascii_t      ascii_o,
  output      logic                 released_o
);

  ps2_pkg::buf_state_t state;

  // New event wins over a transfer in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::buf_empty;
    else if (ev.valid)
      state <= ps2_pkg::buf_full;
    else if (valid_o && ready_i)
      state <= ps2_pkg::buf_empty;
  end

  // Outputs read zero out of reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      scan_code_o <= '0;
      ascii_o     <= '0;
      released_o  <= 1'b0;
    end
    else if (ev.valid)
    begin
      scan_code_o <= ev.scan_code;
      ascii_o     <= ev.ascii;
      released_o  <= ev.released;
    end
  end

  assign valid_o = (state == ps2_pkg::buf_full);

endmodule

`default_nettype wire

/* rtl/ps2_key_decoder.sv */
/*
  Turns raw scan codes into key events. F0 is held and flags the next code.
  Extended E0 prefixes are not trapped and come out as their own events.
  ASCII uses the shift state from before the current code.
*/
`default_nettype none
`include "ps2_macros.svh"

module ps2_key_decoder (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 code_valid_i,
  input  wire ps2_pkg::scan_code_t  code_i,
  output      logic                 shift_o,
  key_event_if.producer             ev
);

  logic             release_hold;
  logic             left_shift, right_shift;
  logic             is_release;
  ps2_pkg::ascii_t  ascii;

  assign is_release = (code_i == `PS2_RELEASE_CODE);

  // Prefix waits for the key code that follows
  always_ff @(posedge clk)
  begin
    if (reset)
      release_hold <= 1'b0;
    else if (code_valid_i)
      release_hold <= is_release;   // Any other code consumes it
  end

  // Make sets, break clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
    end
    else if (code_valid_i)
    begin
      if (code_i == `PS2_LEFT_SHIFT)
        left_shift <= !release_hold;
      if (code_i == `PS2_RIGHT_SHIFT)
        right_shift <= !release_hold;
    end
  end

  assign shift_o = left_shift || right_shift;

  ps2_ascii_map u_ascii_map (
    .code_i  (code_i),
    .shift_i (shift_o),
    .ascii_o (ascii)
  );

  assign ev.valid     = code_valid_i && !is_release; // Same cycle as frame end
  assign ev.scan_code = code_i;
  assign ev.ascii     = ascii;
  assign ev.released  = release_hold;

endmodule

`default_nettype wire

/* rtl/ps2_ascii_map.sv */
/*
  Scan code set 2 to ASCII, US layout, main block keys only.
  Unlisted codes give PS2_UNKNOWN_ASCII. Purely combinational.
*/
`default_nettype none
`include "ps2_macros.svh"

module ps2_ascii_map (
  input  wire ps2_pkg::scan_code_t  code_i,
  input  wire logic                 shift_i,
  output      ps2_pkg::ascii_t      ascii_o
);

  logic [8:0] key;

  assign key = {shift_i, code_i}; // Shift in bit 8

  always_comb
  begin
    casez (key)
      // Control keys, shift ignored
      9'b?_0110_0110: ascii_o = 8'h08; // Backspace
      9'b?_0000_1101: ascii_o = 8'h09; // Tab
      9'b?_0101_1010: ascii_o = 8'h0D; // Enter
      9'b?_0111_0110: ascii_o = 8'h1B; // Esc
      9'b?_0010_1001: ascii_o = 8'h20; // Space
      9'b?_0111_0001: ascii_o = 8'h7F; // Delete
      // Unshifted
      9'h052: ascii_o = 8'h27; // Quote
      9'h041: ascii_o = 8'h2C; // Comma
      9'h04E: ascii_o = 8'h2D;
      9'h049: ascii_o = 8'h2E;
      9'h04A: ascii_o = 8'h2F; // Slash
      9'h045: ascii_o = 8'h30; // Digits 0 to 9
      9'h016: ascii_o = 8'h31;
      9'h01E: ascii_o = 8'h32;
      9'h026: ascii_o = 8'h33;
      9'h025: ascii_o = 8'h34;
      9'h02E: ascii_o = 8'h35;
      9'h036: ascii_o = 8'h36;
      9'h03D: ascii_o = 8'h37;
      9'h03E: ascii_o = 8'h38;
      9'h046: ascii_o = 8'h39;
      9'h04C: ascii_o = 8'h3B; // Semicolon
      9'h055: ascii_o = 8'h3D; // Equals
      9'h054: ascii_o = 8'h5B; // Brackets and backslash
      9'h05D: ascii_o = 8'h5C;
      9'h05B: ascii_o = 8'h5D;
      9'h00E: ascii_o = 8'h60; // Backtick
      9'h01C: ascii_o = 8'h61; // Lower case a to z
      9'h032: ascii_o = 8'h62;
      9'h021: ascii_o = 8'h63;
      9'h023: ascii_o = 8'h64;
      9'h024: ascii_o = 8'h65;
      9'h02B: ascii_o = 8'h66;
      9'h034: ascii_o = 8'h67;
      9'h033: ascii_o = 8'h68;
      9'h043: ascii_o = 8'h69;
      9'h03B: ascii_o = 8'h6A;
      9'h042: ascii_o = 8'h6B;
      9'h04B: ascii_o = 8'h6C;
      9'h03A: ascii_o = 8'h6D;
      9'h031: ascii_o = 8'h6E;
      9'h044: ascii_o = 8'h6F;
      9'h04D: ascii_o = 8'h70;
      9'h015: ascii_o = 8'h71;
      9'h02D: ascii_o = 8'h72;
      9'h01B: ascii_o = 8'h73;
      9'h02C: ascii_o = 8'h74;
      9'h03C: ascii_o = 8'h75;
      9'h02A: ascii_o = 8'h76;
      9'h01D: ascii_o = 8'h77;
      9'h022: ascii_o = 8'h78;
      9'h035: ascii_o = 8'h79;
      9'h01A: ascii_o = 8'h7A;
      // Shifted symbols
      9'h116: ascii_o = 8'h21; // Bang
      9'h152: ascii_o = 8'h22; // Double quote
      9'h126: ascii_o = 8'h23;
      9'h125: ascii_o = 8'h24;
      9'h12E: ascii_o = 8'h25;
      9'h13D: ascii_o = 8'h26;
      9'h146: ascii_o = 8'h28; // Parentheses
      9'h145: ascii_o = 8'h29;
      9'h13E: ascii_o = 8'h2A;
      9'h155: ascii_o = 8'h2B; // Plus
      9'h14C: ascii_o = 8'h3A; // Colon
      9'h141: ascii_o = 8'h3C;
      9'h149: ascii_o = 8'h3E;
      9'h14A: ascii_o = 8'h3F;
      9'h11E: ascii_o = 8'h40; // At sign
      9'h136: ascii_o = 8'h5E; // Caret
      9'h14E: ascii_o = 8'h5F; // Underscore
      9'h154: ascii_o = 8'h7B; // Braces, pipe, tilde
      9'h15D: ascii_o = 8'h7C;
      9'h15B: ascii_o = 8'h7D;
      9'h10E: ascii_o = 8'h7E;
      // Shifted letters, upper case A to Z
      9'h11C: ascii_o = 8'h41;
      9'h132: ascii_o = 8'h42;
      9'h121: ascii_o = 8'h43;
      9'h123: ascii_o = 8'h44;
      9'h124: ascii_o = 8'h45;
      9'h12B: ascii_o = 8'h46;
      9'h134: ascii_o = 8'h47;
      9'h133: ascii_o = 8'h48;
      9'h143: ascii_o = 8'h49;
      9'h13B: ascii_o = 8'h4A;
      9'h142: ascii_o = 8'h4B;
      9'h14B: ascii_o = 8'h4C;
      9'h13A: ascii_o = 8'h4D;
      9'h131: ascii_o = 8'h4E;
      9'h144: ascii_o = 8'h4F;
      9'h14D: ascii_o = 8'h50;
      9'h115: ascii_o = 8'h51;
      9'h12D: ascii_o = 8'h52;
      9'h11B: ascii_o = 8'h53;
      9'h12C: ascii_o = 8'h54;
      9'h13C: ascii_o = 8'h55;
      9'h12A: ascii_o = 8'h56;
      9'h11D: ascii_o = 8'h57;
      9'h122: ascii_o = 8'h58;
      9'h135: ascii_o = 8'h59;
      9'h11A: ascii_o = 8'h5A;
      default: ascii_o = `PS2_UNKNOWN_ASCII; // Unlisted codes, shifted or not
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ps2_rx_frame.sv */
/*
  PS/2 receive framer. Both lines are asynchronous and pass two sync flops.
  Parity and stop bits are shifted in but not checked.
  WATCHDOG_CYCLES of idle-high clock discard a partial frame.
*/
`default_nettype none
`include "ps2_macros.svh"

module ps2_rx_frame #(
  parameter int WATCHDOG_CYCLES = 3000
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 ps2_clk_i,
  input  wire logic                 ps2_data_i,
  output      logic                 code_valid_o,
  output      ps2_pkg::scan_code_t  code_o
);

  localparam int WD_W = $clog2(WATCHDOG_CYCLES + 1);

  logic                         clk_meta, clk_sync;
  logic                         data_meta, data_sync;
  ps2_pkg::rx_state_t           state, state_nxt;
  logic [`PS2_FRAME_BITS-1:0]   shift_q;
  logic [3:0]                   bit_cnt;
  logic [WD_W-1:0]              wd_cnt;
  logic                         wd_done;

  // Sync flops start at idle high so reset gives no false edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end
    else
    begin
      clk_meta  <= ps2_clk_i;
      clk_sync  <= clk_meta;
      data_meta <= ps2_data_i;
      data_sync <= data_meta;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ps2_pkg::rx_clk_high: if (!clk_sync) state_nxt = ps2_pkg::rx_fall;
      ps2_pkg::rx_fall:     state_nxt = ps2_pkg::rx_clk_low; // One-cycle marker
      ps2_pkg::rx_clk_low:  if (clk_sync) state_nxt = ps2_pkg::rx_rise;
      ps2_pkg::rx_rise:     state_nxt = ps2_pkg::rx_clk_high;
      default:              state_nxt = ps2_pkg::rx_clk_high;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::rx_clk_high;
    else
      state <= state_nxt;
  end

  // Data is sampled on the falling edge, LSB first
  always_ff @(posedge clk)
  begin
    if (state == ps2_pkg::rx_fall)
      shift_q <= {data_sync, shift_q[`PS2_FRAME_BITS-1:1]};
  end

  always_ff @(posedge clk)
  begin
    if (reset || code_valid_o)
      bit_cnt <= '0;
    else if (wd_done)
      bit_cnt <= '0;                  // Stalled partial frame
    else if (state == ps2_pkg::rx_fall)
      bit_cnt <= bit_cnt + 4'd1;
  end

  // Idle-high watchdog, restarts on every clock low phase
  always_ff @(posedge clk)
  begin
    if (reset || state != ps2_pkg::rx_clk_high)
      wd_cnt <= '0;
    else if (!wd_done)
      wd_cnt <= wd_cnt + 1'b1;
  end

  assign wd_done = (state == ps2_pkg::rx_clk_high) && (wd_cnt == WD_W'(WATCHDOG_CYCLES));

  assign code_valid_o = (bit_cnt == 4'(`PS2_FRAME_BITS)); // Cleared next cycle
  assign code_o       = shift_q[8:1];                     // Skip start bit

endmodule

`default_nettype wire

/* rtl/key_event_if.sv */
/*
  One decoded key event, decoder to output buffer.
  valid is a single-cycle pulse and cannot be stalled, so there is no ready.
*/
`default_nettype none

interface key_event_if;
  logic                 valid;     // One-cycle event strobe
  ps2_pkg::scan_code_t  scan_code;
  ps2_pkg::ascii_t      ascii;
  logic                 released;  // Code was preceded by F0

  modport producer (output valid, output scan_code, output ascii, output released);
  modport consumer (input valid, input scan_code, input ascii, input released);
endinterface

`default_nettype wire

/* rtl/ps2_pkg.sv */
/*
  Shared types of the PS/2 keyboard receiver.
  Receiver edge states rx_fall and rx_rise last exactly one clk cycle.
*/
`default_nettype none

package ps2_pkg;

  typedef logic [7:0] scan_code_t; // One set 2 scan code
  typedef logic [7:0] ascii_t;

  // PS/2 clock tracking, edge states are one-cycle markers
  typedef enum logic [1:0] {
    rx_clk_high,
    rx_fall,
    rx_clk_low,
    rx_rise
  } rx_state_t;

  // Output holding register
  typedef enum logic {
    buf_empty,
    buf_full
  } buf_state_t;

endpackage

`default_nettype wire

/* rtl/ps2_macros.svh */
/*
  Frame format and special scan codes of the PS/2 keyboard receiver.
  Scan code set 2 only. Extended (E0) codes are passed through as plain codes.
*/
`ifndef PS2_MACROS_SVH
`define PS2_MACROS_SVH

// Start, 8 data, parity, stop
`define PS2_FRAME_BITS 11

`define PS2_RELEASE_CODE 8'hF0 // Key release prefix
`define PS2_LEFT_SHIFT 8'h12
`define PS2_RIGHT_SHIFT 8'h59

// ASCII '.' for unlisted scan codes
`define PS2_UNKNOWN_ASCII 8'h2E

`endif
